// File: hdl/pad_pkg.sv
`default_nettype none

package pad_pkg;

    localparam int num_pads = 2;
    localparam int btn_w    = 8;

    // Address is {pad index, word select}.
    localparam int reg_aw    = 2;
    localparam int pad_iw    = reg_aw - 1;
    localparam int num_words = 2 * num_pads;

    localparam logic held_sel   = 1'b0;
    localparam logic sticky_sel = 1'b1;

    localparam int latch_cycles = 2; // Latch high time in clocks.

    typedef enum logic [1:0] {
        op_write      = 2'd0,
        op_set        = 2'd1, // OR data into the word.
        op_read       = 2'd2,
        op_read_clear = 2'd3  // Old value out, word zeroed.
    } reg_op_t;

    typedef struct packed {
        reg_op_t             op;
        logic [reg_aw-1:0]   addr;
        logic [btn_w-1:0]    wdata;
    } reg_req_t;

endpackage

`default_nettype wire

// File: hdl/pad_scanner.sv
`timescale 1ns/1ns
`default_nettype none

module pad_scanner (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              scan_start,
    output logic                             pad_latch,
    output logic                             pad_clk,
    input  wire  [pad_pkg::num_pads-1:0]     pad_data_n,
    output logic                             req,
    output pad_pkg::reg_req_t                req_data,
    input  wire                              gnt,
    output logic                             scan_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_latch,
        st_shift,
        st_post
    } state_t;

    state_t state;

    logic [$clog2(pad_pkg::latch_cycles)-1:0] latch_cnt;
    logic [$clog2(pad_pkg::btn_w)-1:0]        bit_cnt;
    logic                                     phase;    // Second cycle of a bit slot.
    logic [pad_pkg::reg_aw-1:0]               post_idx;

    logic [pad_pkg::btn_w-1:0] shift_q [pad_pkg::num_pads];
    logic [pad_pkg::btn_w-1:0] prev_q  [pad_pkg::num_pads];

    logic [pad_pkg::pad_iw-1:0] pad_idx;
    logic [pad_pkg::btn_w-1:0]  new_press;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
            latch_cnt <= '0;
            bit_cnt   <= '0;
            phase     <= 1'b0;
            post_idx  <= '0;
            for (int p = 0; p < pad_pkg::num_pads; p++) begin
                prev_q[p] <= '0;
            end
        end else begin
            case (state)
                st_idle: begin
                    if (scan_start) begin
                        pad_latch <= 1'b1;
                        latch_cnt <= '0;
                        state     <= st_latch;
                    end
                end
                st_latch: begin
                    if (latch_cnt == ($bits(latch_cnt))'(pad_pkg::latch_cycles - 1)) begin
                        pad_latch <= 1'b0;
                        bit_cnt   <= '0;
                        phase     <= 1'b0;
                        state     <= st_shift;
                    end else begin
                        latch_cnt <= latch_cnt + 1'b1;
                    end
                end
                st_shift: begin
                    if (!phase) begin
                        // No clock pulse after the last bit.
                        pad_clk <= (bit_cnt != ($bits(bit_cnt))'(pad_pkg::btn_w - 1));
                        phase   <= 1'b1;
                    end else begin
                        pad_clk <= 1'b0;
                        phase   <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == ($bits(bit_cnt))'(pad_pkg::btn_w - 1)) begin
                            post_idx <= '0;
                            state    <= st_post;
                        end
                    end
                end
                st_post: begin
                    if (gnt) begin
                        post_idx <= post_idx + 1'b1;
                        if (&post_idx) begin
                            for (int p = 0; p < pad_pkg::num_pads; p++) begin
                                prev_q[p] <= shift_q[p];
                            end
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Bits arrive MSB first, active low on the wire.
    always_ff @(posedge clk) begin
        if (state == st_shift && !phase) begin
            for (int p = 0; p < pad_pkg::num_pads; p++) begin
                shift_q[p] <= {shift_q[p][pad_pkg::btn_w-2:0], ~pad_data_n[p]};
            end
        end
    end

    // Held writes first, then the sticky updates.
    always_comb begin
        pad_idx   = post_idx[pad_pkg::pad_iw-1:0];
        new_press = shift_q[pad_idx] & ~prev_q[pad_idx];
        if (post_idx[pad_pkg::reg_aw-1]) begin
            req_data.op    = pad_pkg::op_set;
            req_data.addr  = {pad_idx, pad_pkg::sticky_sel};
            req_data.wdata = new_press;
        end else begin
            req_data.op    = pad_pkg::op_write;
            req_data.addr  = {pad_idx, pad_pkg::held_sel};
            req_data.wdata = shift_q[pad_idx];
        end
    end

    assign req       = (state == st_post);
    assign scan_busy = (state != st_idle);

endmodule

`default_nettype wire

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      scan_req,
    input  wire                      host_req,
    input  wire pad_pkg::reg_req_t   scan_data,
    input  wire pad_pkg::reg_req_t   host_data,
    output logic                     scan_gnt,
    output logic                     host_gnt,
    output logic                     mem_valid,
    output pad_pkg::reg_req_t        mem_req
);

    logic last_host; // Host won the last grant.

    // On contention the peer that lost last time goes first.
    always_comb begin
        scan_gnt = scan_req && (!host_req || last_host);
        host_gnt = host_req && (!scan_req || !last_host);
    end

    assign mem_valid = scan_gnt || host_gnt;
    assign mem_req   = host_gnt ? host_data : scan_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_host <= 1'b0;
        end else if (mem_valid) begin
            last_host <= host_gnt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pad_regs.sv
`timescale 1ns/1ns
`default_nettype none

module pad_regs (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              mem_valid,
    input  wire pad_pkg::reg_req_t           mem_req,
    output logic [pad_pkg::btn_w-1:0]        rdata
);

    logic [pad_pkg::btn_w-1:0] mem [pad_pkg::num_words];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < pad_pkg::num_words; w++) begin
                mem[w] <= '0;
            end
        end else if (mem_valid) begin
            case (mem_req.op)
                pad_pkg::op_write: mem[mem_req.addr] <= mem_req.wdata;
                pad_pkg::op_set:   mem[mem_req.addr] <= mem[mem_req.addr] | mem_req.wdata;
                pad_pkg::op_read_clear: begin
                    mem[mem_req.addr] <= '0;
                end
                default: ;
            endcase
        end
    end

    // Old value, one cycle after the read.
    always_ff @(posedge clk) begin
        if (mem_valid && (mem_req.op == pad_pkg::op_read ||
                          mem_req.op == pad_pkg::op_read_clear)) begin
            rdata <= mem[mem_req.addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/host_port.sv
`timescale 1ns/1ns
`default_nettype none

module host_port (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              host_rd,
    input  wire  [pad_pkg::reg_aw-1:0]       host_addr,
    output logic [pad_pkg::btn_w-1:0]        host_rdata,
    output logic                             host_rvalid,
    output logic                             req,
    output pad_pkg::reg_req_t                req_data,
    input  wire                              gnt,
    input  wire  [pad_pkg::btn_w-1:0]        rdata
);

    logic                        pending;
    logic [pad_pkg::reg_aw-1:0]  addr_q;
    logic [pad_pkg::btn_w-1:0]   hold_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending     <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= gnt;
            if (host_rd) begin
                pending <= 1'b1;
            end else if (gnt) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd) begin
            addr_q <= host_addr;
        end
        if (host_rvalid) begin
            hold_q <= rdata;
        end
    end

    assign req = pending;

    // Sticky reads clear the word.
    always_comb begin
        req_data.addr  = addr_q;
        req_data.wdata = '0;
        if (addr_q[0] == pad_pkg::sticky_sel) begin
            req_data.op = pad_pkg::op_read_clear;
        end else begin
            req_data.op = pad_pkg::op_read;
        end
    end

    // Live data in the valid cycle, then the held copy.
    assign host_rdata = host_rvalid ? rdata : hold_q;

endmodule

`default_nettype wire

// File: hdl/pad_input_top.sv
`timescale 1ns/1ns
`default_nettype none

module pad_input_top (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              scan_start,
    output logic                             pad_latch,
    output logic                             pad_clk,
    input  wire  [pad_pkg::num_pads-1:0]     pad_data_n,
    output logic                             scan_busy,
    input  wire                              host_rd,
    input  wire  [pad_pkg::reg_aw-1:0]       host_addr,
    output logic [pad_pkg::btn_w-1:0]        host_rdata,
    output logic                             host_rvalid
);

    logic                       scan_req;
    logic                       scan_gnt;
    logic                       host_req;
    logic                       host_gnt;
    logic                       mem_valid;
    pad_pkg::reg_req_t          scan_data;
    pad_pkg::reg_req_t          host_data;
    pad_pkg::reg_req_t          mem_req;
    logic [pad_pkg::btn_w-1:0]  rdata;

    pad_scanner u_pad_scanner (
        .clk        (clk),
        .rst        (rst),
        .scan_start (scan_start),
        .pad_latch  (pad_latch),
        .pad_clk    (pad_clk),
        .pad_data_n (pad_data_n),
        .req        (scan_req),
        .req_data   (scan_data),
        .gnt        (scan_gnt),
        .scan_busy  (scan_busy)
    );

    host_port u_host_port (
        .clk         (clk),
        .rst         (rst),
        .host_rd     (host_rd),
        .host_addr   (host_addr),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .req         (host_req),
        .req_data    (host_data),
        .gnt         (host_gnt),
        .rdata       (rdata)
    );

    bus_arbiter u_bus_arbiter (
        .clk       (clk),
        .rst       (rst),
        .scan_req  (scan_req),
        .host_req  (host_req),
        .scan_data (scan_data),
        .host_data (host_data),
        .scan_gnt  (scan_gnt),
        .host_gnt  (host_gnt),
        .mem_valid (mem_valid),
        .mem_req   (mem_req)
    );

    pad_regs u_pad_regs (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .rdata     (rdata)
    );

endmodule

`default_nettype wire

// File: bench/pad_model.sv
`timescale 1ns/1ns
`default_nettype none

module pad_model (
    input  wire                                              pad_latch,
    input  wire                                              pad_clk,
    input  wire  [pad_pkg::num_pads-1:0][pad_pkg::btn_w-1:0] buttons,
    output logic [pad_pkg::num_pads-1:0]                     pad_data_n
);

    logic [pad_pkg::btn_w-1:0] sr [pad_pkg::num_pads] = '{default: '0};

    // Latch loads the buttons, each pad clock rise moves to the next bit.
    always @(posedge pad_latch or posedge pad_clk) begin
        for (int p = 0; p < pad_pkg::num_pads; p++) begin
            if (pad_latch) begin
                sr[p] <= buttons[p];
            end else begin
                sr[p] <= {sr[p][pad_pkg::btn_w-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        for (int p = 0; p < pad_pkg::num_pads; p++) begin
            pad_data_n[p] = ~sr[p][pad_pkg::btn_w-1]; // Pressed pulls low.
        end
    end

endmodule

`default_nettype wire

// File: bench/pad_input_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pad_input_tb;

    localparam int num_scans = 6;
    localparam int timeout_cycles = num_scans * 200;

    logic clk = 1'b0;
    logic rst;
    logic scan_start;
    logic host_rd;
    logic [pad_pkg::reg_aw-1:0] host_addr;
    logic pad_latch;
    logic pad_clk;
    logic scan_busy;
    logic host_rvalid;
    logic [pad_pkg::btn_w-1:0] host_rdata;
    logic [pad_pkg::num_pads-1:0] pad_data_n;
    logic [pad_pkg::num_pads-1:0][pad_pkg::btn_w-1:0] pad_buttons;

    logic [pad_pkg::btn_w-1:0] btn        [pad_pkg::num_pads];
    logic [pad_pkg::btn_w-1:0] prev_exp   [pad_pkg::num_pads];
    logic [pad_pkg::btn_w-1:0] held_exp   [pad_pkg::num_pads];
    logic [pad_pkg::btn_w-1:0] sticky_exp [pad_pkg::num_pads];

    logic [15:0] lfsr = 16'd19464;
    int checks = 0;
    int errors = 0;
    int cyc = 0;
    int latch_hi = 0;
    int latch_rises = 0;
    int latch_rise_cyc = 0;
    int clk_pulses = 0;
    logic latch_d = 1'b0;
    logic clk_d = 1'b0;

    always #5 clk = ~clk;

    pad_input_top u_pad_input_top (
        .clk (clk), .rst (rst), .scan_start (scan_start),
        .pad_latch (pad_latch), .pad_clk (pad_clk), .pad_data_n (pad_data_n),
        .scan_busy (scan_busy), .host_rd (host_rd), .host_addr (host_addr),
        .host_rdata (host_rdata), .host_rvalid (host_rvalid)
    );

    pad_model u_pad_model (
        .pad_latch (pad_latch), .pad_clk (pad_clk),
        .buttons (pad_buttons), .pad_data_n (pad_data_n)
    );

    // Pad line activity, counted per sampled edge.
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (pad_latch) begin
            latch_hi++;
            if (!latch_d) begin
                latch_rises++;
                latch_rise_cyc = cyc;
            end
        end
        if (pad_clk && !clk_d) begin
            clk_pulses++;
        end
        latch_d <= pad_latch;
        clk_d   <= pad_clk;
    end

    assert property (@(posedge clk) disable iff (rst) pad_clk |=> !pad_clk)
        else begin
            errors++;
            $display("[FAIL] pad_clk stayed 0x1 for two cycles");
        end

    assert property (@(posedge clk) disable iff (rst) !(pad_latch && pad_clk))
        else begin
            errors++;
            $display("[FAIL] pad_latch 0x1 and pad_clk 0x1 overlap");
        end

    assert property (@(posedge clk) disable iff (rst) host_rvalid |=> !host_rvalid)
        else begin
            errors++;
            $display("[FAIL] host_rvalid stayed 0x1 for two cycles");
        end

    // Taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_byte(output logic [pad_pkg::btn_w-1:0] b);
        for (int i = 0; i < pad_pkg::btn_w; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[pad_pkg::btn_w-2:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [pad_pkg::btn_w-1:0] got,
                               input logic [pad_pkg::btn_w-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic host_read(input logic [pad_pkg::reg_aw-1:0] addr,
                             output logic [pad_pkg::btn_w-1:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        host_rd   <= 1'b1;
        host_addr <= addr;
        @(posedge clk);
        host_rd <= 1'b0;
        @(posedge clk);
        while (!host_rvalid && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        checks++;
        assert (host_rvalid) else begin
            errors++;
            $display("Host read of address %0d got no host_rvalid", addr);
        end
        data = host_rdata;
    endtask

    task automatic read_word_check(input int p, input logic sel);
        logic [pad_pkg::btn_w-1:0] r;
        host_read({p[pad_pkg::pad_iw-1:0], sel}, r);
        if (sel == pad_pkg::held_sel) begin
            check_value($sformatf("held[%0d] host_rdata", p), r, held_exp[p]);
        end else begin
            check_value($sformatf("sticky[%0d] host_rdata", p), r, sticky_exp[p]);
            sticky_exp[p] = '0;
        end
    endtask

    task automatic update_model();
        for (int p = 0; p < pad_pkg::num_pads; p++) begin
            sticky_exp[p] = sticky_exp[p] | (btn[p] & ~prev_exp[p]);
            prev_exp[p]   = btn[p];
            held_exp[p]   = btn[p];
        end
    endtask

    task automatic run_scan(input logic restrike);
        int start_cyc;
        int waited;
        int lh0;
        int lr0;
        int cp0;
        lh0 = latch_hi;
        lr0 = latch_rises;
        cp0 = clk_pulses;
        waited = 0;
        @(posedge clk);
        scan_start <= 1'b1;
        for (int p = 0; p < pad_pkg::num_pads; p++) begin
            pad_buttons[p] <= btn[p];
        end
        @(posedge clk);
        start_cyc = cyc;
        scan_start <= 1'b0;
        if (restrike) begin
            repeat (4) @(posedge clk);
            scan_start <= 1'b1;
            @(posedge clk);
            scan_start <= 1'b0;
        end
        @(posedge clk);
        while (scan_busy && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        checks += 4;
        assert (!scan_busy) else begin
            errors++;
            $display("Scan never finished, scan_busy stuck high");
        end
        assert (latch_hi - lh0 == 2 && latch_rises - lr0 == 1) else begin
            errors++;
            $display("[FAIL] pad_latch high 0x%0h cycles in 0x%0h pulses expected 0x2 in 0x1",
                     latch_hi - lh0, latch_rises - lr0);
        end
        assert (latch_rise_cyc == start_cyc + 1) else begin
            errors++;
            $display("[FAIL] pad_latch rose at cycle 0x%0h expected 0x%0h",
                     latch_rise_cyc, start_cyc + 1);
        end
        assert (clk_pulses - cp0 == 7) else begin
            errors++;
            $display("[FAIL] pad_clk pulses 0x%0h expected 0x7", clk_pulses - cp0);
        end
    endtask

    initial begin
        logic [pad_pkg::btn_w-1:0] r;
        logic [pad_pkg::btn_w-1:0] r2;
        logic [pad_pkg::btn_w-1:0] old_held;
        logic [pad_pkg::btn_w-1:0] old_sticky;
        logic [pad_pkg::btn_w-1:0] fresh;
        logic [pad_pkg::reg_aw-1:0] ca;
        int cp;
        rst         = 1'b1;
        scan_start  = 1'b0;
        host_rd     = 1'b0;
        host_addr   = '0;
        pad_buttons = '0;
        for (int p = 0; p < pad_pkg::num_pads; p++) begin
            prev_exp[p]   = '0;
            held_exp[p]   = '0;
            sticky_exp[p] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checks++;
        assert (!pad_latch && !pad_clk && !scan_busy && !host_rvalid) else begin
            errors++;
            $display("[FAIL] after reset pad_latch 0x%0h pad_clk 0x%0h scan_busy 0x%0h %s",
                     pad_latch, pad_clk, scan_busy, $sformatf("host_rvalid 0x%0h", host_rvalid));
        end
        for (int a = 0; a < pad_pkg::num_words; a++) begin
            host_read(a[pad_pkg::reg_aw-1:0], r);
            check_value($sformatf("word[%0d] host_rdata", a), r, '0);
        end

        for (int s = 0; s < num_scans; s++) begin
            for (int p = 0; p < pad_pkg::num_pads; p++) begin
                draw_byte(btn[p]);
            end
            if (s < 3) begin
                run_scan(s == 2);
                update_model();
            end else begin
                // Host read races the scanner's posting phase.
                ca = (s == 3) ? 2'b11 : (s == 4) ? 2'b00 : 2'b01;
                cp = int'(ca[pad_pkg::reg_aw-1]);
                old_held   = held_exp[cp];
                old_sticky = sticky_exp[cp];
                fresh      = btn[cp] & ~prev_exp[cp];
                fork
                    run_scan(1'b0);
                    begin
                        repeat (15 + s) @(posedge clk);
                        host_read(ca, r);
                    end
                join
                update_model();
                checks++;
                if (ca[0] == pad_pkg::held_sel) begin
                    assert (r === old_held || r === held_exp[cp]) else begin
                        errors++;
                        $display("[FAIL] held host_rdata 0x%02h expected 0x%02h or 0x%02h",
                                 r, old_held, held_exp[cp]);
                    end
                end else begin
                    host_read(ca, r2);
                    assert ((r === old_sticky && r2 === fresh) ||
                            (r === (old_sticky | fresh) && r2 === '0)) else begin
                        errors++;
                        $display("[FAIL] sticky host_rdata 0x%02h then 0x%02h, old 0x%02h new 0x%02h",
                                 r, r2, old_sticky, fresh);
                    end
                    sticky_exp[cp] = '0;
                end
            end
            for (int p = 0; p < pad_pkg::num_pads; p++) begin
                read_word_check(p, pad_pkg::held_sel);
            end
            if (s == 1 || s == 5) begin
                for (int k = 0; k < 2; k++) begin
                    for (int p = 0; p < pad_pkg::num_pads; p++) begin
                        read_word_check(p, pad_pkg::sticky_sel);
                    end
                end
            end
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", timeout_cycles);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: pad_input.f
hdl/pad_pkg.sv
hdl/pad_scanner.sv
hdl/bus_arbiter.sv
hdl/pad_regs.sv
hdl/host_port.sv
hdl/pad_input_top.sv
bench/pad_model.sv
bench/pad_input_tb.sv
